// ==== rtl/pool_cfg_pkg.sv ====
// ====================
// Job configuration and datapath widths for the max-pooling engine.
// Shared by the controller, the map fetch unit and the reduce unit.
// Reference these definitions by scoped name.
// ====================

`default_nettype none

package pool_cfg_pkg;

    // ====================
    // Fixed widths
    // ====================

    // One activation, unsigned
    localparam int act_width = 8;

    // Point indices and memory addresses
    localparam int idx_width = 12;

    // Channels per group, handled side by side
    localparam int num_lanes = 4;

    // Neighbour and group counts
    localparam int cnt_width = 4;

    // ====================
    // Types
    // ====================

    // Job descriptor, 20 bits
    typedef struct packed {
        logic [idx_width-1:0] num_points;
        logic [cnt_width-1:0] num_nb;
        logic [cnt_width-1:0] num_grp;
    } pool_cfg_t;

    // One activation vector, lane 0 in the low byte
    typedef logic [num_lanes-1:0][act_width-1:0] lanes_t;

endpackage

`default_nettype wire

// ==== rtl/pool_bus_pkg.sv ====
// ====================
// Payload structs for the activation read tags and the result writes.
// Widths come from the job configuration package.
// ====================

`default_nettype none

package pool_bus_pkg;

    // Rides along with each activation read while it is in flight
    typedef struct packed {
        logic [pool_cfg_pkg::idx_width-1:0] wr_addr;
        // First neighbour loads the running maximum
        logic                               first;
        // Final neighbour releases the result
        logic                               last;
    } ofm_tag_t;

    // One pooled result on its way out, 44 bits
    typedef struct packed {
        logic [pool_cfg_pkg::idx_width-1:0] addr;
        pool_cfg_pkg::lanes_t               data;
    } wr_req_t;

endpackage

`default_nettype wire

// ==== rtl/pool_loop_counter.sv ====
// ====================
// Wrapping loop counter with a run-time last value.
// Counts 0..last_value, one step per cycle with step high.
// ====================

`default_nettype none

module pool_loop_counter #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear,
    input  logic             step,
    input  logic [WIDTH-1:0] last_value,
    output logic [WIDTH-1:0] count,
    output logic             wrap
);

    // High during the final iteration of the loop
    assign wrap = (count == last_value);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (step) begin
            count <= wrap ? '0 : count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pool_fifo.sv ====
// ====================
// Small synchronous FIFO, circular buffer of DEPTH entries.
// Payload type set by T. Holds read tags and result writes.
// ====================

`default_nettype none

module pool_fifo #(
    parameter int  DEPTH = 2,
    parameter type T     = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,
    output T     out_data,
    output logic out_valid,
    input  logic out_ready,
    output logic empty
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready  = (count != CW'(DEPTH));
    assign out_valid = (count != '0);
    assign empty     = ~out_valid;
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Occupancy only moves when exactly one side transfers
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pool_ctrl.sv ====
// ====================
// Job FSM of the pooling engine.
// Walks points, then per point the map reads, then groups x neighbours of
// activation reads. Builds the tag of every activation read.
// ====================

`default_nettype none

module pool_ctrl (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  pool_cfg_pkg::pool_cfg_t                cfg,
    input  logic                                   cfg_valid,
    output logic                                   cfg_ready,
    output pool_cfg_pkg::pool_cfg_t                job,
    output logic                                   map_start,
    output logic                                   map_req_valid,
    input  logic                                   map_req_ready,
    input  logic                                   map_done,
    output logic [pool_cfg_pkg::idx_width-1:0]     point,
    output logic [pool_cfg_pkg::cnt_width-1:0]     nb,
    output logic [pool_cfg_pkg::cnt_width-1:0]     grp,
    output logic                                   ofm_req_valid_int,
    input  logic                                   ofm_issue,
    output pool_bus_pkg::ofm_tag_t                 tag,
    input  logic                                   reduce_idle
);

    localparam int AW = pool_cfg_pkg::idx_width;

    typedef enum logic [1:0] {S_IDLE, S_MAP, S_OFM, S_DRAIN} state_t;

    state_t state;
    state_t next_state;
    logic   map_hs;
    logic   nb_wrap;
    logic   grp_wrap;
    logic   pt_wrap;
    logic   grp_step;
    logic   pt_step;

    // ====================
    // Handshakes and loop steps
    // ====================

    assign cfg_ready         = (state == S_IDLE);
    assign map_req_valid     = (state == S_MAP);
    assign ofm_req_valid_int = (state == S_OFM) && map_done;
    assign map_hs            = map_req_valid && map_req_ready;
    assign grp_step          = ofm_issue && nb_wrap;
    assign pt_step           = grp_step && grp_wrap;

    // New fill of the index buffer for the first and every next point
    assign map_start = (cfg_ready && cfg_valid) || (pt_step && !pt_wrap);

    always_ff @(posedge clk) begin
        if (cfg_ready && cfg_valid) begin
            job <= cfg;
        end
    end

    // Neighbour counter serves the map phase and the activation phase
    pool_loop_counter #(.WIDTH(pool_cfg_pkg::cnt_width)) u_nb_cnt (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (cfg_ready),
        .step       (map_hs || ofm_issue),
        .last_value (job.num_nb - 1'b1),
        .count      (nb),
        .wrap       (nb_wrap)
    );

    pool_loop_counter #(.WIDTH(pool_cfg_pkg::cnt_width)) u_grp_cnt (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (cfg_ready),
        .step       (grp_step),
        .last_value (job.num_grp - 1'b1),
        .count      (grp),
        .wrap       (grp_wrap)
    );

    pool_loop_counter #(.WIDTH(AW)) u_pt_cnt (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (cfg_ready),
        .step       (pt_step),
        .last_value (job.num_points - 1'b1),
        .count      (point),
        .wrap       (pt_wrap)
    );

    // Result slot is point * num_grp + grp
    assign tag.wr_addr = AW'(point * job.num_grp) + AW'(grp);
    assign tag.first   = (nb == '0);
    assign tag.last    = nb_wrap;

    // ====================
    // State machine
    // ====================

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE:  if (cfg_valid) next_state = S_MAP;
            S_MAP:   if (map_hs && nb_wrap) next_state = S_OFM;
            S_OFM:   if (pt_step) next_state = pt_wrap ? S_DRAIN : S_MAP;
            // Last write must have left the engine
            S_DRAIN: if (reduce_idle) next_state = S_IDLE;
            default: next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/map_fetch.sv ====
// ====================
// Map read unit. Forms the map address of each neighbour and keeps the
// returned indices of the current point in a K_MAX entry buffer.
// ====================

`default_nettype none

module map_fetch #(
    parameter int K_MAX = 8
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic [pool_cfg_pkg::idx_width-1:0] point,
    input  logic [pool_cfg_pkg::cnt_width-1:0] nb,
    input  logic [pool_cfg_pkg::cnt_width-1:0] num_nb,
    output logic [pool_cfg_pkg::idx_width-1:0] map_addr,
    input  logic [pool_cfg_pkg::idx_width-1:0] map_rsp_data,
    input  logic                               map_rsp_valid,
    output logic                               map_rsp_ready,
    output logic                               map_done,
    input  logic [pool_cfg_pkg::cnt_width-1:0] rd_nb,
    output logic [pool_cfg_pkg::idx_width-1:0] nb_index
);

    localparam int AW = pool_cfg_pkg::idx_width;
    localparam int BW = $clog2(K_MAX);

    logic [AW-1:0]                      idx_buf [K_MAX];
    logic [pool_cfg_pkg::cnt_width-1:0] fill;

    // Map rows are K_MAX entries apart
    assign map_addr = AW'(point * K_MAX) + AW'(nb);

    // Buffer always has room, responses never stall
    assign map_rsp_ready = 1'b1;

    assign map_done = (fill == num_nb);
    assign nb_index = idx_buf[rd_nb[BW-1:0]];

    // Fill pointer, reset per point
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill <= '0;
        end else if (start) begin
            fill <= '0;
        end else if (map_rsp_valid) begin
            fill <= fill + 1'b1;
        end
    end

    // Responses come back in request order
    always_ff @(posedge clk) begin
        if (map_rsp_valid) begin
            idx_buf[fill[BW-1:0]] <= map_rsp_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ofm_max_reduce.sv ====
// ====================
// Activation read and max unit.
// Issues one read per neighbour and group, keeps the lane-wise unsigned
// maximum over the responses and queues one write per finished group.
// ====================

`default_nettype none

module ofm_max_reduce #(
    parameter int TAG_DEPTH = 4,
    parameter int WR_DEPTH  = 2
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [pool_cfg_pkg::idx_width-1:0] nb_index,
    input  logic [pool_cfg_pkg::cnt_width-1:0] grp,
    input  logic [pool_cfg_pkg::cnt_width-1:0] num_grp,
    input  pool_bus_pkg::ofm_tag_t             tag_in,
    input  logic                               req_valid_int,
    output logic [pool_cfg_pkg::idx_width-1:0] ofm_addr,
    output logic                               ofm_req_valid,
    input  logic                               ofm_req_ready,
    output logic                               ofm_issue,
    input  pool_cfg_pkg::lanes_t               ofm_rsp_data,
    input  logic                               ofm_rsp_valid,
    output logic                               ofm_rsp_ready,
    output pool_bus_pkg::wr_req_t              wr,
    output logic                               wr_valid,
    input  logic                               wr_ready,
    output logic                               idle
);

    localparam int AW = pool_cfg_pkg::idx_width;

    pool_bus_pkg::ofm_tag_t tag_head;
    logic                   tag_in_ready;
    logic                   tag_valid;
    logic                   tag_empty;
    logic                   rsp_hs;
    pool_cfg_pkg::lanes_t   max_q;
    logic [AW-1:0]          addr_q;
    logic                   emit;
    pool_bus_pkg::wr_req_t  wr_push;
    logic                   wr_in_ready;
    logic                   wr_empty;

    // ====================
    // Request side
    // ====================

    assign ofm_addr      = AW'(nb_index * num_grp) + AW'(grp);
    assign ofm_req_valid = req_valid_int && tag_in_ready;
    assign ofm_issue     = ofm_req_valid && ofm_req_ready;

    pool_fifo #(.DEPTH(TAG_DEPTH), .T(pool_bus_pkg::ofm_tag_t)) u_tag_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (tag_in),
        .in_valid  (ofm_issue),
        .in_ready  (tag_in_ready),
        .out_data  (tag_head),
        .out_valid (tag_valid),
        .out_ready (rsp_hs),
        .empty     (tag_empty)
    );

    // ====================
    // Response side
    // ====================

    // Hold off while a result is on its way into the queue, so that its
    // slot is still free when it lands
    assign ofm_rsp_ready = tag_valid && wr_in_ready && !emit;
    assign rsp_hs        = ofm_rsp_valid && ofm_rsp_ready;

    always_ff @(posedge clk) begin
        if (rsp_hs) begin
            for (int i = 0; i < pool_cfg_pkg::num_lanes; i++) begin
                if (tag_head.first || (ofm_rsp_data[i] > max_q[i])) begin
                    max_q[i] <= ofm_rsp_data[i];
                end
            end
            addr_q <= tag_head.wr_addr;
        end
    end

    // Final neighbour of a group
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            emit <= 1'b0;
        end else begin
            emit <= rsp_hs && tag_head.last;
        end
    end

    assign wr_push.addr = addr_q;
    assign wr_push.data = max_q;

    pool_fifo #(.DEPTH(WR_DEPTH), .T(pool_bus_pkg::wr_req_t)) u_wr_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (wr_push),
        .in_valid  (emit),
        .in_ready  (wr_in_ready),
        .out_data  (wr),
        .out_valid (wr_valid),
        .out_ready (wr_ready),
        .empty     (wr_empty)
    );

    // Nothing in flight, nothing queued
    assign idle = tag_empty && wr_empty && !emit;

endmodule

`default_nettype wire

// ==== rtl/pool_top.sv ====
// ====================
// Top level of the max-pooling engine.
// One job per cfg transfer; cfg_ready comes back once the last
// write of the job is accepted. All ports are valid/ready.
// ====================

`default_nettype none

module pool_top #(
    parameter int K_MAX     = 8,
    parameter int TAG_DEPTH = 4,
    parameter int WR_DEPTH  = 2
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  pool_cfg_pkg::pool_cfg_t            cfg,
    input  logic                               cfg_valid,
    output logic                               cfg_ready,
    output logic [pool_cfg_pkg::idx_width-1:0] map_addr,
    output logic                               map_req_valid,
    input  logic                               map_req_ready,
    input  logic [pool_cfg_pkg::idx_width-1:0] map_rsp_data,
    input  logic                               map_rsp_valid,
    output logic                               map_rsp_ready,
    output logic [pool_cfg_pkg::idx_width-1:0] ofm_addr,
    output logic                               ofm_req_valid,
    input  logic                               ofm_req_ready,
    input  pool_cfg_pkg::lanes_t               ofm_rsp_data,
    input  logic                               ofm_rsp_valid,
    output logic                               ofm_rsp_ready,
    output pool_bus_pkg::wr_req_t              wr,
    output logic                               wr_valid,
    input  logic                               wr_ready
);

    pool_cfg_pkg::pool_cfg_t            job;
    logic                               map_start;
    logic                               map_done;
    logic [pool_cfg_pkg::idx_width-1:0] point;
    logic [pool_cfg_pkg::cnt_width-1:0] nb;
    logic [pool_cfg_pkg::cnt_width-1:0] grp;
    logic                               ofm_req_valid_int;
    logic                               ofm_issue;
    pool_bus_pkg::ofm_tag_t             tag;
    logic                               reduce_idle;
    logic [pool_cfg_pkg::idx_width-1:0] nb_index;

    pool_ctrl u_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .cfg               (cfg),
        .cfg_valid         (cfg_valid),
        .cfg_ready         (cfg_ready),
        .job               (job),
        .map_start         (map_start),
        .map_req_valid     (map_req_valid),
        .map_req_ready     (map_req_ready),
        .map_done          (map_done),
        .point             (point),
        .nb                (nb),
        .grp               (grp),
        .ofm_req_valid_int (ofm_req_valid_int),
        .ofm_issue         (ofm_issue),
        .tag               (tag),
        .reduce_idle       (reduce_idle)
    );

    map_fetch #(.K_MAX(K_MAX)) u_map_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (map_start),
        .point         (point),
        .nb            (nb),
        .num_nb        (job.num_nb),
        .map_addr      (map_addr),
        .map_rsp_data  (map_rsp_data),
        .map_rsp_valid (map_rsp_valid),
        .map_rsp_ready (map_rsp_ready),
        .map_done      (map_done),
        .rd_nb         (nb),
        .nb_index      (nb_index)
    );

    ofm_max_reduce #(.TAG_DEPTH(TAG_DEPTH), .WR_DEPTH(WR_DEPTH)) u_reduce (
        .clk           (clk),
        .rst_n         (rst_n),
        .nb_index      (nb_index),
        .grp           (grp),
        .num_grp       (job.num_grp),
        .tag_in        (tag),
        .req_valid_int (ofm_req_valid_int),
        .ofm_addr      (ofm_addr),
        .ofm_req_valid (ofm_req_valid),
        .ofm_req_ready (ofm_req_ready),
        .ofm_issue     (ofm_issue),
        .ofm_rsp_data  (ofm_rsp_data),
        .ofm_rsp_valid (ofm_rsp_valid),
        .ofm_rsp_ready (ofm_rsp_ready),
        .wr            (wr),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .idle          (reduce_idle)
    );

endmodule

`default_nettype wire

// ==== verification/pool_checker.sv ====
// ====================
// Handshake assertions on the top-level ports of the pooling engine.
// Bound into pool_top, reports through failing assertions only.
// ====================

`default_nettype none

module pool_checker (
    input logic                               clk,
    input logic                               rst_n,
    input logic                               cfg_ready,
    input logic [pool_cfg_pkg::idx_width-1:0] map_addr,
    input logic                               map_req_valid,
    input logic                               map_req_ready,
    input logic [pool_cfg_pkg::idx_width-1:0] ofm_addr,
    input logic                               ofm_req_valid,
    input logic                               ofm_req_ready,
    input pool_bus_pkg::wr_req_t              wr,
    input logic                               wr_valid,
    input logic                               wr_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    // Valid and payload hold until the transfer
    map_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        map_req_valid && !map_req_ready |=> map_req_valid && $stable(map_addr))
        else $error("map request dropped or changed before ready");

    ofm_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_req_valid && !ofm_req_ready |=> ofm_req_valid && $stable(ofm_addr))
        else $error("activation request dropped or changed before ready");

    wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr))
        else $error("write dropped or changed before ready");

    // No result may leave once the job is reported finished
    wr_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_valid && cfg_ready))
        else $error("write valid while the engine is idle");

endmodule

bind pool_top pool_checker u_pool_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_ready     (cfg_ready),
    .map_addr      (map_addr),
    .map_req_valid (map_req_valid),
    .map_req_ready (map_req_ready),
    .ofm_addr      (ofm_addr),
    .ofm_req_valid (ofm_req_valid),
    .ofm_req_ready (ofm_req_ready),
    .wr            (wr),
    .wr_valid      (wr_valid),
    .wr_ready      (wr_ready)
);

`default_nettype wire

// ==== verification/pool_tb.sv ====
// ====================
// Testbench for the max-pooling engine.
// Reads the jobs, memory contents and expected writes from the trace,
// models the map and activation memories with random stalls and delays,
// and checks every write in order. Run from the project root.
// ====================

`default_nettype none

module pool_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int K_MAX       = 8;
    localparam int AW          = pool_cfg_pkg::idx_width;
    localparam int CW          = pool_cfg_pkg::cnt_width;
    localparam int TRACE_WORDS = 512;
    localparam int MEM_WORDS   = 4096;

    logic                    clk;
    logic                    rst_n;
    pool_cfg_pkg::pool_cfg_t cfg;
    logic                    cfg_valid;
    logic                    cfg_ready;
    logic [AW-1:0]           map_addr;
    logic                    map_req_valid;
    logic                    map_req_ready;
    logic [AW-1:0]           map_rsp_data;
    logic                    map_rsp_valid;
    logic                    map_rsp_ready;
    logic [AW-1:0]           ofm_addr;
    logic                    ofm_req_valid;
    logic                    ofm_req_ready;
    pool_cfg_pkg::lanes_t    ofm_rsp_data;
    logic                    ofm_rsp_valid;
    logic                    ofm_rsp_ready;
    pool_bus_pkg::wr_req_t   wr;
    logic                    wr_valid;
    logic                    wr_ready;

    // Memory images and in-flight responses
    logic [31:0]             trace_mem [TRACE_WORDS];
    logic [AW-1:0]           map_mem [MEM_WORDS];
    pool_cfg_pkg::lanes_t    ofm_mem [MEM_WORDS];
    logic [AW-1:0]           map_dat_q [$];
    int                      map_due_q [$];
    pool_cfg_pkg::lanes_t    ofm_dat_q [$];
    int                      ofm_due_q [$];
    logic [AW-1:0]           exp_addr_q [$];
    pool_cfg_pkg::lanes_t    exp_data_q [$];
    int                      cycle;
    int                      cycle_limit;
    int                      wr_total;
    int                      trace_pos;

    pool_top #(.K_MAX(K_MAX), .TAG_DEPTH(4), .WR_DEPTH(2)) u_pool_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg           (cfg),
        .cfg_valid     (cfg_valid),
        .cfg_ready     (cfg_ready),
        .map_addr      (map_addr),
        .map_req_valid (map_req_valid),
        .map_req_ready (map_req_ready),
        .map_rsp_data  (map_rsp_data),
        .map_rsp_valid (map_rsp_valid),
        .map_rsp_ready (map_rsp_ready),
        .ofm_addr      (ofm_addr),
        .ofm_req_valid (ofm_req_valid),
        .ofm_req_ready (ofm_req_ready),
        .ofm_rsp_data  (ofm_rsp_data),
        .ofm_rsp_valid (ofm_rsp_valid),
        .ofm_rsp_ready (ofm_rsp_ready),
        .wr            (wr),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ====================
    // Reporting
    // ====================

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "run aborted");
    endtask

    // ====================
    // Trace access
    // ====================

    function automatic logic [31:0] next_word();
        logic [31:0] w;
        w = trace_mem[trace_pos];
        trace_pos = trace_pos + 1;
        return w;
    endfunction

    // Skips over every job and sums up the expected writes
    function automatic int count_expected_writes(input int num_jobs);
        int total;
        int n;
        total = 0;
        for (int j = 0; j < num_jobs; j++) begin
            trace_pos = trace_pos + 3;
            n = int'(next_word());
            trace_pos = trace_pos + 2 * n;
            n = int'(next_word());
            trace_pos = trace_pos + 2 * n;
            n = int'(next_word());
            trace_pos = trace_pos + 2 * n;
            total = total + n;
        end
        return total;
    endfunction

    task automatic load_job(output pool_cfg_pkg::pool_cfg_t job_cfg, output int n_writes);
        logic [31:0] w;
        logic [31:0] a;
        int          n;
        // Stray reads see a value tied to the full address
        for (int i = 0; i < MEM_WORDS; i++) begin
            map_mem[i] = ~i[AW-1:0];
            ofm_mem[i] = {8'hee, i[AW-1:0], i[AW-1:0]};
        end
        w = next_word();
        job_cfg.num_points = w[AW-1:0];
        w = next_word();
        job_cfg.num_nb = w[CW-1:0];
        w = next_word();
        job_cfg.num_grp = w[CW-1:0];
        n = int'(next_word());
        repeat (n) begin
            a = next_word();
            w = next_word();
            map_mem[a[AW-1:0]] = w[AW-1:0];
        end
        n = int'(next_word());
        repeat (n) begin
            a = next_word();
            ofm_mem[a[AW-1:0]] = next_word();
        end
        n_writes = int'(next_word());
        repeat (n_writes) begin
            a = next_word();
            exp_addr_q.push_back(a[AW-1:0]);
            exp_data_q.push_back(next_word());
        end
    endtask

    // ====================
    // Job sequencing
    // ====================

    task automatic check_after_reset();
        repeat (5) begin
            @(posedge clk);
            check_value("cfg_ready", 64'(1), 64'(cfg_ready));
            check_value("wr_valid", 64'(0), 64'(wr_valid));
            check_value("map_req_valid", 64'(0), 64'(map_req_valid));
            check_value("ofm_req_valid", 64'(0), 64'(ofm_req_valid));
        end
    endtask

    task automatic run_job(input pool_cfg_pkg::pool_cfg_t job_cfg, input int n_writes);
        int start_count;
        start_count = wr_total;
        @(posedge clk);
        cfg       <= job_cfg;
        cfg_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!cfg_ready);
        cfg_valid <= 1'b0;
        // Back in idle only once the final write has gone out
        do begin
            @(posedge clk);
        end while (!cfg_ready);
        check_value("job write count", 64'(n_writes), 64'(wr_total - start_count));
    endtask

    initial begin
        pool_cfg_pkg::pool_cfg_t job_cfg;
        int                      n_writes;
        int                      num_jobs;
        int                      total_writes;
        void'($urandom(33));
        rst_n     = 1'b0;
        cfg       = '0;
        cfg_valid = 1'b0;
        $readmemh("verification/pool_trace.txt", trace_mem);
        trace_pos    = 0;
        num_jobs     = int'(next_word());
        total_writes = count_expected_writes(num_jobs);
        if (num_jobs == 0 || total_writes == 0) begin
            abort_run("Trace file holds no jobs or no expected writes");
        end
        cycle_limit = 200 * total_writes + 500;
        trace_pos   = 1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        check_after_reset();
        for (int j = 0; j < num_jobs; j++) begin
            load_job(job_cfg, n_writes);
            run_job(job_cfg, n_writes);
        end
        $display("*** PASSED ***");
        $finish;
    end

    // ====================
    // Memory models
    // ====================

    // Map memory, random ready, in-order answers after 1 to 3 cycles
    initial begin
        map_req_ready = 1'b0;
        map_rsp_valid = 1'b0;
        map_rsp_data  = '0;
        forever begin
            @(posedge clk);
            if (map_rsp_valid && map_rsp_ready) begin
                void'(map_dat_q.pop_front());
                void'(map_due_q.pop_front());
            end
            if (map_req_valid && map_req_ready) begin
                map_dat_q.push_back(map_mem[map_addr]);
                map_due_q.push_back(cycle + int'($urandom % 3));
            end
            map_req_ready <= ($urandom % 4) != 0;
            if (map_due_q.size() > 0 && map_due_q[0] <= cycle) begin
                map_rsp_valid <= 1'b1;
                map_rsp_data  <= map_dat_q[0];
            end else begin
                map_rsp_valid <= 1'b0;
            end
        end
    end

    // Activation memory, same behaviour, response held until ready
    initial begin
        ofm_req_ready = 1'b0;
        ofm_rsp_valid = 1'b0;
        ofm_rsp_data  = '0;
        forever begin
            @(posedge clk);
            if (ofm_rsp_valid && ofm_rsp_ready) begin
                void'(ofm_dat_q.pop_front());
                void'(ofm_due_q.pop_front());
            end
            if (ofm_req_valid && ofm_req_ready) begin
                ofm_dat_q.push_back(ofm_mem[ofm_addr]);
                ofm_due_q.push_back(cycle + int'($urandom % 3));
            end
            ofm_req_ready <= ($urandom % 4) != 0;
            if (ofm_due_q.size() > 0 && ofm_due_q[0] <= cycle) begin
                ofm_rsp_valid <= 1'b1;
                ofm_rsp_data  <= ofm_dat_q[0];
            end else begin
                ofm_rsp_valid <= 1'b0;
            end
        end
    end

    initial begin
        wr_ready = 1'b0;
        forever begin
            @(posedge clk);
            wr_ready <= ($urandom % 3) != 0;
        end
    end

    // Write monitor, results leave in trace order
    always @(posedge clk) begin
        if (rst_n && wr_valid && wr_ready) begin
            if (exp_addr_q.size() == 0) begin
                abort_run("Write accepted with no expected write left in the trace");
            end else begin
                check_value("wr.addr", 64'(exp_addr_q[0]), 64'(wr.addr));
                check_value("wr.data", 64'(exp_data_q[0]), 64'(wr.data));
                void'(exp_addr_q.pop_front());
                void'(exp_data_q.pop_front());
                wr_total <= wr_total + 1;
            end
        end
    end

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle_limit != 0 && cycle >= cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles, the jobs did not finish", cycle));
        end
    end

endmodule

`default_nettype wire

// ==== verification/pool_trace.txt ====
// Hex words in order. First word is the job count; each job has num_points num_nb num_grp,
// then counted (address value) pairs for map, activations and expected writes, in that order.
2

// Job 1: one neighbour per point, two groups
2 1 2
2
000 003  008 001
4
002 11223344  003 a0b0c0d0
006 05f0807f  007 ff000102
4
000 05f0807f  001 ff000102
002 11223344  003 a0b0c0d0

// Job 2: eight neighbours per point with repeated indices
2 8 2
10
000 000  001 001  002 002  003 001
004 000  005 002  006 002  007 000
008 003  009 003  00a 001  00b 003
00c 001  00d 001  00e 003  00f 003
8
000 10203040  001 01020304  002 40302010  003 80000001
004 2a2a2a2a  005 00ff0000  006 0000007f  007 7f000080
4
000 40303040  001 80ff0304
002 4030207f  003 80000080

// ==== flist.f ====
rtl/pool_cfg_pkg.sv
rtl/pool_bus_pkg.sv
rtl/pool_loop_counter.sv
rtl/pool_fifo.sv
rtl/pool_ctrl.sv
rtl/map_fetch.sv
rtl/ofm_max_reduce.sv
rtl/pool_top.sv
verification/pool_checker.sv
verification/pool_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the max-pooling testbench with Verilator.
# The result is taken from the simulation log.

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module pool_tb \
    -Mdir "$BUILD_DIR" -o pool_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed, see $BUILD_LOG"
    exit 1
fi

"./$BUILD_DIR/pool_sim" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q -F '*** PASSED ***' "$SIM_LOG"; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1
